// ==== sources.f ====
verilog/ipcpTablePkg.sv
verilog/prefetchReqPkg.sv
verilog/bram.sv
verilog/ipcpClassifier.sv
verilog/prefetchQueue.sv
verilog/prefetchIssuer.sv
verilog/ipcpPrefetcher.sv
tb/ipcpPrefetcher_checker.sv
tb/ipcpPrefetcher_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := ipcpPrefetcher_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/ipcpPrefetcher_tb.sv ====
module ipcpPrefetcher_tb
    import ipcpTablePkg::*;
    import prefetchReqPkg::*;
();

    localparam int QUEUE_DEPTH = 4;
    localparam int DEGREE = 2;
    localparam int TOTAL_VISITS = 108; // 6 NL, 12 CS, 50 GS, 40 under back-pressure
    localparam int TIMEOUT_CYCLES = TOTAL_VISITS * DEGREE * 40;

    logic clk = 1'b0;
    logic RST_vout;
    logic [31:0] ipAddr;
    logic [31:0] visitAddr;
    logic visitValid;
    logic preReady;
    logic [31:0] preAddr;
    logic preValid;

    logic [31:0] expQ [$];
    logic [31:0] expAddr;
    logic checkOn = 1'b1;
    logic bpDone = 1'b0;

    // Reference IP table
    logic mIpValid [2**IP_INDEX_BITS] = '{default: 1'b0};
    logic [IP_TAG_BITS-1:0] mIpTag [2**IP_INDEX_BITS];
    logic [8:0] mLastLine [2**IP_INDEX_BITS];
    logic signed [STRIDE_BITS-1:0] mStride [2**IP_INDEX_BITS];
    int mConf [2**IP_INDEX_BITS];
    logic mStream [2**IP_INDEX_BITS];
    logic mAscend [2**IP_INDEX_BITS];
    // Reference region table
    logic mRegValid [2**REGION_INDEX_BITS] = '{default: 1'b0};
    logic [63:0] mTouched [2**REGION_INDEX_BITS];
    int mDirCount [2**REGION_INDEX_BITS];
    int mLastOff [2**REGION_INDEX_BITS];
    logic mTrained [2**REGION_INDEX_BITS];

    ipcpPrefetcher #(.QUEUE_DEPTH(QUEUE_DEPTH), .DEGREE(DEGREE)) uut
    (
        .clk(clk), .RST_vout(RST_vout), .ipAddr(ipAddr), .visitAddr(visitAddr),
        .visitValid(visitValid), .preReady(preReady), .preAddr(preAddr), .preValid(preValid)
    );

    bind ipcpPrefetcher ipcpPrefetcher_checker #(.DEPTH(QUEUE_DEPTH)) assertChk
    (
        .clk(clk), .RST_vout(RST_vout), .preValid(preValid), .preReady(preReady),
        .preAddr(preAddr), .qValid(qValid), .pushValid(pushValid), .qPop(qPop)
    );

    always #5 clk = ~clk;

    task automatic reportFail(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitEmpty();
        do
            @(posedge clk);
        while (expQ.size() != 0);
        #1;
    endtask

    function automatic logic [31:0] regionAddr(input logic [16:0] upper,
                                               input logic [3:0] region,
                                               input logic [5:0] offset);
        return {upper, region, offset, 5'($urandom_range(31, 0))};
    endfunction

    // Expected addresses per visit from the IPCP rules
    task automatic predictVisit(input logic [31:0] ip, input logic [31:0] addr);
        logic [LINE_ADDR_BITS-1:0] line;
        logic [IP_INDEX_BITS-1:0] idx;
        logic [REGION_INDEX_BITS-1:0] rIdx;
        logic oldTrained;
        logic signed [STRIDE_BITS-1:0] curStride;
        logic signed [STRIDE_BITS-1:0] oldStride;
        logic signed [STRIDE_BITS-1:0] reqStride;
        int off;
        int oldConf;
        int oldDir;
        int k;
        line = addr[31:LINE_OFFSET_BITS];
        idx = ip[IP_INDEX_BITS+1:2];
        rIdx = line[9:6];
        off = int'(line[5:0]);
        if (!mRegValid[rIdx])
        begin
            mRegValid[rIdx] = 1'b1;
            mTouched[rIdx] = '0;
            mDirCount[rIdx] = 0;
            mLastOff[rIdx] = 0;
            mTrained[rIdx] = 1'b0;
        end
        oldTrained = mTrained[rIdx];
        oldDir = mDirCount[rIdx];
        mTouched[rIdx][off] = 1'b1;
        if (off > mLastOff[rIdx] && oldDir < 31)
            mDirCount[rIdx] = oldDir + 1;
        else if (off < mLastOff[rIdx] && oldDir > -32)
            mDirCount[rIdx] = oldDir - 1;
        mLastOff[rIdx] = off;
        if ($countones(mTouched[rIdx]) >= 48)
            mTrained[rIdx] = 1'b1;
        reqStride = 8'sd1; // Next line by default
        if (!mIpValid[idx] || mIpTag[idx] != ip[16:8])
        begin
            mIpValid[idx] = 1'b1;
            mIpTag[idx] = ip[16:8];
            mStride[idx] = '0;
            mConf[idx] = 0;
            mStream[idx] = 1'b0;
            mAscend[idx] = 1'b0;
        end
        else
        begin
            curStride = STRIDE_BITS'(line[8:0] - mLastLine[idx]);
            oldConf = mConf[idx];
            oldStride = mStride[idx];
            if (curStride == oldStride)
                mConf[idx] = (oldConf == 3) ? 3 : oldConf + 1;
            else
                mConf[idx] = (oldConf == 0) ? 0 : oldConf - 1;
            if (oldConf == 0)
                mStride[idx] = curStride;
            if (oldTrained)
            begin
                mStream[idx] = 1'b1;
                mAscend[idx] = oldDir >= 0;
            end
            if (mStream[idx])
                reqStride = mAscend[idx] ? 8'sd1 : -8'sd1;
            else if (oldConf >= 2)
                reqStride = oldStride;
        end
        mLastLine[idx] = line[8:0];
        for (k = 1; k <= DEGREE; k++)
            expQ.push_back({line + LINE_ADDR_BITS'(k * reqStride), 5'd0});
    endtask

    task automatic doVisit(input logic [31:0] ip, input logic [31:0] addr, input logic predict);
        if (predict)
            predictVisit(ip, addr);
        ipAddr = ip;
        visitAddr = addr;
        visitValid = 1'b1;
        idle(1);
        visitValid = 1'b0;
    endtask

    // Handshake completes at the next rising edge
    always @(negedge clk)
    begin
        if (RST_vout === 1'b1 && preValid && preReady && checkOn)
        begin
            if (expQ.size() == 0)
                reportFail("prefetch issued with none expected");
            else
            begin
                expAddr = expQ.pop_front();
                assert (preAddr == expAddr)
                else reportFail($sformatf("preAddr %h, expected %h", preAddr, expAddr));
            end
        end
    end

    // Checker assertion failures end the run at once
    initial
    begin
        wait (uut.assertChk.failCount != 0);
        $display("Checker assertion failed at time %0t", $time);
        $display("Done: errors found");
        $fatal(1, "Assertion failure");
    end

    initial
    begin
        #(TIMEOUT_CYCLES * 10);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        logic [31:0] ips [4];
        logic [31:0] addrWalk;
        logic signed [7:0] csStride;
        logic [16:0] upper;
        int offs [4];
        int c;
        int j;
        int k;
        int tmp;
        int quiet;
        tmp = $urandom(32'he37d5478);
        RST_vout = 1'b0;
        ipAddr = '0;
        visitAddr = '0;
        visitValid = 1'b0;
        preReady = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        RST_vout = 1'b1;
        repeat (20)
        begin
            @(negedge clk);
            assert (!preValid) else reportFail("preValid high with no visits");
        end
        idle(1);

        // Each new IP gets next line prefetches
        for (j = 0; j < 6; j++)
        begin
            doVisit({15'($urandom), 9'($urandom), 6'(j), 2'b00},
                    regionAddr(17'($urandom), 4'(j), 6'($urandom)), 1'b1);
            idle(3);
        end
        waitEmpty();

        // Constant stride walk by one IP
        ips[0] = {15'($urandom), 9'($urandom), 6'd10, 2'b00};
        csStride = 8'($urandom_range(6, 1));
        if ($urandom_range(1, 0) == 1)
            csStride = -csStride;
        addrWalk = regionAddr(17'($urandom), 4'd9, 6'd32);
        repeat (12)
        begin
            doVisit(ips[0], addrWalk, 1'b1);
            idle(3);
            addrWalk = addrWalk + 32'(csStride * 32);
        end
        waitEmpty();

        // Four IPs fill region 12 with a rising trend
        upper = 17'($urandom);
        for (j = 0; j < 4; j++)
            ips[j] = {15'($urandom), 9'($urandom), 6'(20 + j), 2'b00};
        for (c = 0; c < 12; c++)
        begin
            for (j = 0; j < 4; j++)
                offs[j] = 4 * c + j;
            for (j = 3; j > 0; j--)
            begin
                k = $urandom_range(j, 0);
                tmp = offs[j];
                offs[j] = offs[k];
                offs[k] = tmp;
            end
            for (j = 0; j < 4; j++)
            begin
                doVisit(ips[(c + j) % 4], regionAddr(upper, 4'd12, 6'(offs[j])), 1'b1);
                idle(3);
            end
        end
        doVisit(ips[0], regionAddr(upper, 4'd12, 6'd50), 1'b1); // Trained region now
        idle(3);
        doVisit(ips[1], regionAddr(upper, 4'd12, 6'd57), 1'b1);
        idle(3);
        waitEmpty();

        // Visit every cycle under back-pressure so requests get dropped
        checkOn = 1'b0;
        fork
            begin
                repeat (40)
                    doVisit($urandom, $urandom, 1'b0);
                bpDone = 1'b1;
            end
            begin
                while (!bpDone)
                begin
                    preReady = 1'b0;
                    idle($urandom_range(6, 1));
                    preReady = 1'b1;
                    idle($urandom_range(3, 1));
                end
            end
        join
        preReady = 1'b1;
        quiet = 0;
        while (quiet < 8)
        begin
            @(negedge clk);
            quiet = preValid ? 0 : quiet + 1;
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== tb/ipcpPrefetcher_checker.sv ====
module ipcpPrefetcher_checker #(
    parameter int DEPTH = 4
)
(
    input logic        clk,
    input logic        RST_vout,
    input logic        preValid,
    input logic        preReady,
    input logic [31:0] preAddr,
    input logic        qValid,
    input logic        pushValid,
    input logic        qPop
);

    localparam int OCC_BITS = $clog2(DEPTH + 1) + 1;

    logic [OCC_BITS-1:0] occupancy; // Queue entries seen from its ports
    int failCount = 0;

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
            occupancy <= '0;
        else
            occupancy <= occupancy + OCC_BITS'(pushValid) - OCC_BITS'(qPop && qValid);
    end

    resetQuiet: assert property (@(posedge clk) !RST_vout |=> !preValid && !qValid)
    else
    begin
        $error("Prefetch output or queue active right after reset");
        failCount = failCount + 1;
    end

    // Held output while stalled
    heldOnStall: assert property (@(posedge clk) disable iff (!RST_vout)
        preValid && !preReady |=> preValid && $stable(preAddr))
    else
    begin
        $error("Prefetch output changed while preReady was low");
        failCount = failCount + 1;
    end

    noOverflow: assert property (@(posedge clk) disable iff (!RST_vout)
        pushValid |-> occupancy < OCC_BITS'(DEPTH))
    else
    begin
        $error("Queue pushed while full");
        failCount = failCount + 1;
    end

endmodule

// ==== verilog/ipcpPrefetcher.sv ====
module ipcpPrefetcher
    import prefetchReqPkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int DEGREE = 2
)
(
    input  logic        clk,
    input  logic        RST_vout,
    input  logic [31:0] ipAddr,
    input  logic [31:0] visitAddr,
    input  logic        visitValid,
    input  logic        preReady,
    output logic [31:0] preAddr,
    output logic        preValid
);

    logic pushValid;
    prefetchReq pushReq;
    logic creditReturn;
    logic qValid;
    prefetchReq qReq;
    logic qPop;

    ipcpClassifier #(.QUEUE_DEPTH(QUEUE_DEPTH)) classifier
    (
        .clk(clk), .RST_vout(RST_vout),
        .ipAddr(ipAddr), .visitAddr(visitAddr), .visitValid(visitValid),
        .creditReturn(creditReturn),
        .pushValid(pushValid), .pushReq(pushReq)
    );

    prefetchQueue #(.DEPTH(QUEUE_DEPTH), .payloadT(prefetchReq)) queue
    (
        .clk(clk), .RST_vout(RST_vout),
        .pushValid(pushValid), .pushData(pushReq), .pop(qPop),
        .qValid(qValid), .headData(qReq), .creditReturn(creditReturn)
    );

    prefetchIssuer #(.DEGREE(DEGREE)) issuer
    (
        .clk(clk), .RST_vout(RST_vout),
        .qValid(qValid), .qReq(qReq), .preReady(preReady),
        .qPop(qPop), .preAddr(preAddr), .preValid(preValid)
    );

endmodule

// ==== verilog/prefetchIssuer.sv ====
module prefetchIssuer
    import ipcpTablePkg::*;
    import prefetchReqPkg::*;
#(
    parameter int DEGREE = 2
)
(
    input  logic        clk,
    input  logic        RST_vout,
    input  logic        qValid,
    input  prefetchReq  qReq,
    input  logic        preReady,
    output logic        qPop,
    output logic [31:0] preAddr,
    output logic        preValid
);

    localparam int STEP_BITS = $clog2(DEGREE + 1);

    prefetchReq curReq;
    logic [STEP_BITS-1:0] step; // Runs 1 to DEGREE
    logic signed [LINE_ADDR_BITS-1:0] stepOffset;
    logic [LINE_ADDR_BITS-1:0] lineAddr;

    assign qPop = !preValid && qValid;

    assign stepOffset = $signed(curReq.stride) * $signed({1'b0, step});
    assign lineAddr = curReq.baseLine + stepOffset;
    assign preAddr = {lineAddr, {LINE_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            preValid <= 1'b0;
            step <= '0;
        end
        else if (qPop)
        begin
            preValid <= 1'b1;
            step <= STEP_BITS'(1);
        end
        else if (preValid && preReady)
        begin
            if (step == STEP_BITS'(DEGREE))
                preValid <= 1'b0;
            else
                step <= step + 1'b1;
        end
    end

    // Held while the steps are issued
    always_ff @(posedge clk)
    begin
        if (qPop)
            curReq <= qReq;
    end

endmodule

// ==== verilog/prefetchQueue.sv ====
module prefetchQueue #(
    parameter int DEPTH = 4,
    parameter type payloadT = logic [31:0]
)
(
    input  logic    clk,
    input  logic    RST_vout,
    input  logic    pushValid,
    input  payloadT pushData,
    input  logic    pop,
    output logic    qValid,
    output payloadT headData,
    output logic    creditReturn
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_BITS = $clog2(DEPTH + 1);

    payloadT mem [DEPTH];
    logic [PTR_BITS-1:0] wrPtr, rdPtr;
    logic [COUNT_BITS-1:0] count;
    logic doPop;

    // Wraps for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign qValid = count != '0;
    assign headData = mem[rdPtr];
    assign doPop = pop && qValid;

    always_ff @(posedge clk)
    begin
        if (pushValid)
            mem[wrPtr] <= pushData;
    end

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            creditReturn <= 1'b0;
        end
        else
        begin
            if (pushValid)
                wrPtr <= nextPtr(wrPtr);
            if (doPop)
                rdPtr <= nextPtr(rdPtr);
            count <= count + COUNT_BITS'(pushValid) - COUNT_BITS'(doPop);
            creditReturn <= doPop; // One credit per pop
        end
    end

endmodule

// ==== verilog/ipcpClassifier.sv ====
module ipcpClassifier
    import ipcpTablePkg::*;
    import prefetchReqPkg::*;
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic        clk,
    input  logic        RST_vout,
    input  logic [31:0] ipAddr,
    input  logic [31:0] visitAddr,
    input  logic        visitValid,
    input  logic        creditReturn,
    output logic        pushValid,
    output prefetchReq  pushReq
);

    localparam int LAST_LINE_BITS = STRIDE_BITS + 1;
    localparam int REGION_OFF_BITS = 6; // 64 lines per region
    localparam int TRAIN_LINES = 48;
    localparam int CREDIT_BITS = $clog2(QUEUE_DEPTH + 1);
    localparam logic signed [5:0] DIR_MAX = 6'sb011111;
    localparam logic signed [5:0] DIR_MIN = 6'sb100000;

    typedef struct packed
    {
        logic [IP_TAG_BITS-1:0] tag;
        logic [LAST_LINE_BITS-1:0] lastLine;
        logic signed [STRIDE_BITS-1:0] stride;
        logic [1:0] conf;
        logic stream;
        logic dir; // 1 ascending
    } ipEntry;

    typedef struct packed
    {
        logic [5:0] regionHits;
        logic [2**REGION_OFF_BITS-1:0] touched;
        logic [5:0] distinct;
        logic signed [5:0] dirCount;
        logic [REGION_OFF_BITS-1:0] lastOffset;
        logic trained;
    } regionEntry;

    logic [IP_INDEX_BITS-1:0] ipRaddr, ipIdx0;
    logic [IP_TAG_BITS-1:0] ipTag0;
    logic [REGION_INDEX_BITS-1:0] regionRaddr, regionIdx0;
    logic [LINE_ADDR_BITS-1:0] line0;
    logic [REGION_OFF_BITS-1:0] regionOff;
    logic valid0;
    logic [2**IP_INDEX_BITS-1:0] ipValid;
    logic [2**REGION_INDEX_BITS-1:0] regionValid;
    logic ipValidRd, regionValidRd;
    ipEntry ipRd, ipNext;
    regionEntry regionRd, regionCur, regionNext;
    logic ipHit;
    logic signed [STRIDE_BITS-1:0] curStride, reqStride;
    accessClass reqClass;
    logic [CREDIT_BITS-1:0] credits;
    logic pushNow;

    assign ipRaddr = ipAddr[IP_INDEX_BITS+1:2];
    assign regionRaddr = visitAddr[LINE_OFFSET_BITS+REGION_OFF_BITS +: REGION_INDEX_BITS];
    assign regionIdx0 = line0[REGION_OFF_BITS +: REGION_INDEX_BITS];
    assign regionOff = line0[REGION_OFF_BITS-1:0];

    bram #(.DATA_WIDTH($bits(ipEntry)), .ADDR_WIDTH(IP_INDEX_BITS)) ipTable
    (
        .clk(clk), .raddr(ipRaddr), .waddr(ipIdx0),
        .din(ipNext), .we(valid0), .dout(ipRd)
    );

    bram #(.DATA_WIDTH($bits(regionEntry)), .ADDR_WIDTH(REGION_INDEX_BITS)) regionTable
    (
        .clk(clk), .raddr(regionRaddr), .waddr(regionIdx0),
        .din(regionNext), .we(valid0), .dout(regionRd)
    );

    // Region update
    always_comb
    begin
        regionCur = regionValidRd ? regionRd : '0;
        regionNext = regionCur;
        if (!(&regionCur.regionHits))
            regionNext.regionHits = regionCur.regionHits + 1'b1;
        regionNext.touched = regionCur.touched | ((2**REGION_OFF_BITS)'(1) << regionOff);
        if (!regionCur.touched[regionOff] && !(&regionCur.distinct))
            regionNext.distinct = regionCur.distinct + 1'b1;
        if (regionOff > regionCur.lastOffset && regionCur.dirCount != DIR_MAX)
            regionNext.dirCount = regionCur.dirCount + 6'sd1;
        else if (regionOff < regionCur.lastOffset && regionCur.dirCount != DIR_MIN)
            regionNext.dirCount = regionCur.dirCount - 6'sd1;
        regionNext.lastOffset = regionOff;
        regionNext.trained = regionCur.trained | (regionNext.distinct >= 6'(TRAIN_LINES));
    end

    // IP update and classification
    always_comb
    begin
        ipHit = ipValidRd && ipRd.tag == ipTag0;
        curStride = STRIDE_BITS'(line0[LAST_LINE_BITS-1:0] - ipRd.lastLine);
        ipNext = ipRd;
        reqClass = NL;
        reqStride = 8'sd1;
        if (!ipHit)
        begin
            ipNext = '0; // Reallocate
            ipNext.tag = ipTag0;
            ipNext.lastLine = line0[LAST_LINE_BITS-1:0];
        end
        else
        begin
            ipNext.lastLine = line0[LAST_LINE_BITS-1:0];
            if (curStride == ipRd.stride)
                ipNext.conf = (&ipRd.conf) ? ipRd.conf : ipRd.conf + 2'd1;
            else
                ipNext.conf = (ipRd.conf == 2'd0) ? ipRd.conf : ipRd.conf - 2'd1;
            if (ipRd.conf == 2'd0)
                ipNext.stride = curStride;
            if (regionCur.trained)
            begin
                ipNext.stream = 1'b1;
                ipNext.dir = !regionCur.dirCount[5];
            end
            if (ipNext.stream)
            begin
                reqClass = GS;
                reqStride = ipNext.dir ? 8'sd1 : -8'sd1;
            end
            else if (ipRd.conf >= 2'd2)
            begin
                reqClass = CS;
                reqStride = ipRd.stride;
            end
        end
    end

    assign pushNow = valid0 && credits != '0; // No credit, request dropped

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            valid0 <= 1'b0;
            pushValid <= 1'b0;
            credits <= CREDIT_BITS'(QUEUE_DEPTH);
            ipValid <= '0;
            regionValid <= '0;
            ipValidRd <= 1'b0;
            regionValidRd <= 1'b0;
        end
        else
        begin
            valid0 <= visitValid;
            pushValid <= pushNow;
            credits <= credits - CREDIT_BITS'(pushNow) + CREDIT_BITS'(creditReturn);
            ipValidRd <= ipValid[ipRaddr] | (valid0 && ipIdx0 == ipRaddr);
            regionValidRd <= regionValid[regionRaddr] | (valid0 && regionIdx0 == regionRaddr);
            if (valid0)
            begin
                ipValid[ipIdx0] <= 1'b1;
                regionValid[regionIdx0] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        ipIdx0 <= ipRaddr;
        ipTag0 <= ipAddr[IP_INDEX_BITS+2 +: IP_TAG_BITS];
        line0 <= visitAddr[31:LINE_OFFSET_BITS];
        pushReq.baseLine <= line0;
        pushReq.stride <= reqStride;
        pushReq.reqClass <= reqClass;
    end

endmodule

// ==== verilog/bram.sv ====
module bram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
)
(
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  we,
    output logic [DATA_WIDTH-1:0] dout
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= din;
        if (we && waddr == raddr)
            dout <= din; // Write first on collision
        else
            dout <= mem[raddr];
    end

endmodule

// ==== verilog/prefetchReqPkg.sv ====
package prefetchReqPkg;

    import ipcpTablePkg::*;

    localparam int LINE_ADDR_BITS = 27; // 32 bit byte address minus line offset

    // One classified access, expanded later into DEGREE lines
    typedef struct packed
    {
        logic [LINE_ADDR_BITS-1:0] baseLine;
        logic signed [STRIDE_BITS-1:0] stride;
        accessClass reqClass;
    } prefetchReq;

endpackage

// ==== verilog/ipcpTablePkg.sv ====
package ipcpTablePkg;

    // Access classes, code 2 stays free for complex stride
    typedef enum logic [1:0]
    {
        NL = 2'd0,
        CS = 2'd1,
        GS = 2'd3
    } accessClass;

    // IP table, index from ipAddr[7:2] and tag from ipAddr[16:8]
    localparam int IP_INDEX_BITS = 6;
    localparam int IP_TAG_BITS = 9;

    // Region table covers 2 KB regions
    localparam int REGION_INDEX_BITS = 4;

    localparam int LINE_OFFSET_BITS = 5; // 32 byte lines

    // Signed line stride
    localparam int STRIDE_BITS = 8;

endpackage
